// ==== Makefile ====
# Verilator build and run of the decode stage testbench

TOP := decode_stage_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/base_decoder.sv ====
////////////////////////////////////////
// RV32I decoder with CSR and system ops, combinational
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module base_decoder (
  input  wire [31:0]                   instr_rdata,
  output rv_decode_pkg::decoder_ctrl_t ctrl
);

  rv_decode_pkg::opcode_e       opcode;
  rv_decode_pkg::decoder_ctrl_t dec;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [31:0]                  imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                         legal;

  assign opcode = rv_decode_pkg::opcode_e'(instr_rdata[6:0]);
  assign funct3 = instr_rdata[14:12];
  assign funct7 = instr_rdata[31:25];

  // Sign-extended immediates of the five formats
  assign imm_i = {{20{instr_rdata[31]}}, instr_rdata[31:20]};
  assign imm_s = {{20{instr_rdata[31]}}, instr_rdata[31:25], instr_rdata[11:7]};
  assign imm_b = {{20{instr_rdata[31]}}, instr_rdata[7], instr_rdata[30:25],
                  instr_rdata[11:8], 1'b0};
  assign imm_u = {instr_rdata[31:12], 12'b0};
  assign imm_j = {{12{instr_rdata[31]}}, instr_rdata[19:12], instr_rdata[20],
                  instr_rdata[30:21], 1'b0};

  always_comb begin
    dec              = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    dec.illegal_insn = 1'b0;
    // Register addresses pass through on every accepted word
    dec.rd           = instr_rdata[11:7];
    dec.rs1          = instr_rdata[19:15];
    dec.rs2          = instr_rdata[24:20];
    legal            = 1'b1;
    case (opcode)
      rv_decode_pkg::OPCODE_LUI, rv_decode_pkg::OPCODE_AUIPC: begin
        dec.alu_en   = 1'b1;
        dec.op_a_sel = (opcode == rv_decode_pkg::OPCODE_LUI) ? rv_decode_pkg::OP_A_ZERO
                                                            : rv_decode_pkg::OP_A_PC;
        dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
        dec.rd_we    = 1'b1;
        dec.imm      = imm_u;
      end
      rv_decode_pkg::OPCODE_JAL, rv_decode_pkg::OPCODE_JALR: begin
        // ALU forms the target while C carries pc+4 to rd
        dec.alu_en   = 1'b1;
        dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
        dec.op_c_sel = rv_decode_pkg::OP_C_PC4;
        dec.rd_we    = 1'b1;
        if (opcode == rv_decode_pkg::OPCODE_JAL) begin
          dec.op_a_sel = rv_decode_pkg::OP_A_PC;
          dec.imm      = imm_j;
        end else begin
          dec.op_a_sel = rv_decode_pkg::OP_A_REG;
          dec.imm      = imm_i;
          legal        = funct3 == 3'b000;
        end
      end
      rv_decode_pkg::OPCODE_BRANCH: begin
        // Compare rs1 against rs2 on C, offset rides on B
        dec.alu_en   = 1'b1;
        dec.op_a_sel = rv_decode_pkg::OP_A_REG;
        dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
        dec.op_c_sel = rv_decode_pkg::OP_C_REG;
        dec.imm      = imm_b;
        case (funct3)
          3'b000:  dec.alu_op = rv_decode_pkg::ALU_EQ;
          3'b001:  dec.alu_op = rv_decode_pkg::ALU_NE;
          3'b100:  dec.alu_op = rv_decode_pkg::ALU_LT;
          3'b101:  dec.alu_op = rv_decode_pkg::ALU_GE;
          3'b110:  dec.alu_op = rv_decode_pkg::ALU_LTU;
          3'b111:  dec.alu_op = rv_decode_pkg::ALU_GEU;
          default: legal = 1'b0;
        endcase
      end
      rv_decode_pkg::OPCODE_LOAD, rv_decode_pkg::OPCODE_STORE: begin
        // Address is rs1 plus offset, size straight from funct3
        dec.lsu_en   = 1'b1;
        dec.op_a_sel = rv_decode_pkg::OP_A_REG;
        dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
        dec.lsu_size = funct3[1:0];
        if (opcode == rv_decode_pkg::OPCODE_LOAD) begin
          dec.lsu_signed = !funct3[2];
          dec.rd_we      = 1'b1;
          dec.imm        = imm_i;
          legal          = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        end else begin
          dec.lsu_we   = 1'b1;
          dec.op_c_sel = rv_decode_pkg::OP_C_REG;
          dec.imm      = imm_s;
          legal        = funct3 inside {3'b000, 3'b001, 3'b010};
        end
      end
      rv_decode_pkg::OPCODE_OP_IMM, rv_decode_pkg::OPCODE_OP: begin
        dec.alu_en   = 1'b1;
        dec.op_a_sel = rv_decode_pkg::OP_A_REG;
        dec.rd_we    = 1'b1;
        if (opcode == rv_decode_pkg::OPCODE_OP) begin
          dec.op_b_sel = rv_decode_pkg::OP_B_REG;
          // Funct7 0100000 only for sub and sra, other funct7 belong to extensions
          legal = funct7 == 7'h00 || (funct7 == 7'h20 && funct3 inside {3'b000, 3'b101});
        end else begin
          dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
          dec.imm      = imm_i;
          // Shift immediates keep their upper bits clear apart from srai
          legal = funct3[1:0] != 2'b01 || funct7 == 7'h00 ||
                  (funct3 == 3'b101 && funct7 == 7'h20);
        end
        case (funct3)
          3'b000:  dec.alu_op = (opcode == rv_decode_pkg::OPCODE_OP && funct7[5]) ?
                                rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
          3'b001:  dec.alu_op = rv_decode_pkg::ALU_SLL;
          3'b010:  dec.alu_op = rv_decode_pkg::ALU_SLT;
          3'b011:  dec.alu_op = rv_decode_pkg::ALU_SLTU;
          3'b100:  dec.alu_op = rv_decode_pkg::ALU_XOR;
          3'b101:  dec.alu_op = funct7[5] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
          3'b110:  dec.alu_op = rv_decode_pkg::ALU_OR;
          default: dec.alu_op = rv_decode_pkg::ALU_AND;
        endcase
      end
      rv_decode_pkg::OPCODE_MISC_MEM: begin
        // Fence and fence.i drain through the system unit
        dec.sys_en = 1'b1;
        legal      = funct3[2:1] == 2'b00;
      end
      rv_decode_pkg::OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          // Ecall, ebreak, mret and wfi with rd and rs1 zero
          dec.sys_en = 1'b1;
          legal      = instr_rdata[19:7] == 13'd0 &&
                       instr_rdata[31:20] inside {12'h000, 12'h001, 12'h302, 12'h105};
        end else begin
          // CSR address on B, immediate forms take uimm from the rs1 field
          dec.csr_en   = 1'b1;
          dec.op_a_sel = funct3[2] ? rv_decode_pkg::OP_A_NONE : rv_decode_pkg::OP_A_REG;
          dec.op_b_sel = rv_decode_pkg::OP_B_IMM;
          dec.rd_we    = 1'b1;
          dec.imm      = imm_i;
          legal        = funct3 != 3'b100;
        end
      end
      default: legal = 1'b0;
    endcase
    ctrl = legal ? dec : rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
  end

  ////////////////////////////////////////
  // Checks on each settled word

  // An illegal result carries no stray fields into the selector
  a_base_idle: assert property (@(instr_rdata)
    ctrl.illegal_insn |-> ctrl == rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN);

  // Only uncompressed words ever reach a functional unit
  a_base_uncompressed: assert property (@(instr_rdata)
    (ctrl.alu_en || ctrl.csr_en || ctrl.sys_en || ctrl.lsu_en) |-> instr_rdata[1:0] == 2'b11);

endmodule

`default_nettype wire

// ==== hdl/bitmanip_decoder.sv ====
////////////////////////////////////////
// Decoder for the supported bit-manipulation ops, combinational
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module bitmanip_decoder (
  input  wire [31:0]                   instr_rdata,
  output rv_decode_pkg::decoder_ctrl_t ctrl
);

  rv_decode_pkg::alu_op_e alu_op;
  logic                   match;

  always_comb begin
    match  = instr_rdata[6:0] == rv_decode_pkg::OPCODE_OP;
    alu_op = rv_decode_pkg::ALU_ADD;
    // Keyed on funct7 and funct3 together
    case ({instr_rdata[31:25], instr_rdata[14:12]})
      {7'h20, 3'b111}: alu_op = rv_decode_pkg::ALU_ANDN;
      {7'h20, 3'b110}: alu_op = rv_decode_pkg::ALU_ORN;
      {7'h20, 3'b100}: alu_op = rv_decode_pkg::ALU_XNOR;
      {7'h05, 3'b100}: alu_op = rv_decode_pkg::ALU_MIN;
      {7'h05, 3'b101}: alu_op = rv_decode_pkg::ALU_MINU;
      {7'h05, 3'b110}: alu_op = rv_decode_pkg::ALU_MAX;
      {7'h05, 3'b111}: alu_op = rv_decode_pkg::ALU_MAXU;
      default:         match  = 1'b0;
    endcase

    ctrl = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (match) begin
      ctrl.illegal_insn = 1'b0;
      ctrl.alu_en       = 1'b1;
      ctrl.alu_op       = alu_op;
      ctrl.op_a_sel     = rv_decode_pkg::OP_A_REG;
      ctrl.op_b_sel     = rv_decode_pkg::OP_B_REG;
      ctrl.rd_we        = 1'b1;
      ctrl.rd           = instr_rdata[11:7];
      ctrl.rs1          = instr_rdata[19:15];
      ctrl.rs2          = instr_rdata[24:20];
    end
  end

  // Idle output must be the exact illegal word so the selector can skip it
  a_bm_idle: assert property (@(instr_rdata)
    ctrl.illegal_insn |-> ctrl == rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN);

endmodule

`default_nettype wire

// ==== hdl/decode_select.sv ====
////////////////////////////////////////
// Chooses the sub-decoder result that matched, extensions gated
// by parameter, and checks the chosen control word
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module decode_select #(
  parameter bit M_EXT = 1'b1,
  parameter bit B_EXT = 1'b1
) (
  input  wire rv_decode_pkg::decoder_ctrl_t base_ctrl,
  input  wire rv_decode_pkg::decoder_ctrl_t md_ctrl,
  input  wire rv_decode_pkg::decoder_ctrl_t bm_ctrl,
  input  wire                               opcode_valid,
  output rv_decode_pkg::decoder_ctrl_t      ctrl_mux
);

  logic op_ab_used;
  logic op_c_used;

  // Priority base, then mul/div, then bitmanip
  always_comb begin
    ctrl_mux = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (opcode_valid) begin
      if (!base_ctrl.illegal_insn) begin
        ctrl_mux = base_ctrl;
      end else if (M_EXT && !md_ctrl.illegal_insn) begin
        ctrl_mux = md_ctrl;
      end else if (B_EXT && !bm_ctrl.illegal_insn) begin
        ctrl_mux = bm_ctrl;
      end
    end
  end

  ////////////////////////////////////////
  // Operand usage and unit enables

  assign op_ab_used = ctrl_mux.op_a_sel != rv_decode_pkg::OP_A_NONE ||
                      ctrl_mux.op_b_sel != rv_decode_pkg::OP_B_NONE;
  assign op_c_used  = ctrl_mux.op_c_sel != rv_decode_pkg::OP_C_NONE;

  // A or B only feed the ALU, divider, CSR unit or LSU
  a_op_ab_usage: assert property (@(ctrl_mux)
    op_ab_used |-> (ctrl_mux.alu_en || ctrl_mux.div_en || ctrl_mux.csr_en || ctrl_mux.lsu_en) &&
                   !(ctrl_mux.mul_en || ctrl_mux.sys_en));

  // C is a link address or compare value for the ALU, or store data
  a_op_c_usage: assert property (@(ctrl_mux)
    op_c_used |-> ctrl_mux.alu_en || (ctrl_mux.lsu_en && ctrl_mux.lsu_we));

  // Exactly one unit runs the word, or it is illegal
  a_unit_onehot: assert property (@(ctrl_mux)
    opcode_valid |-> $onehot({ctrl_mux.alu_en, ctrl_mux.mul_en, ctrl_mux.div_en,
                              ctrl_mux.csr_en, ctrl_mux.sys_en, ctrl_mux.lsu_en,
                              ctrl_mux.illegal_insn}));

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
////////////////////////////////////////
// Decode stage top, one instruction per strobe and the control
// word registered one cycle later
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
  parameter bit M_EXT = 1'b1,
  parameter bit B_EXT = 1'b1
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          instr_valid,
  input  wire [31:0]                   instr_rdata,
  output logic                         ctrl_valid,
  output rv_decode_pkg::decoder_ctrl_t ctrl
);

  rv_decode_pkg::decoder_ctrl_t base_ctrl;
  rv_decode_pkg::decoder_ctrl_t md_ctrl;
  rv_decode_pkg::decoder_ctrl_t bm_ctrl;
  rv_decode_pkg::decoder_ctrl_t ctrl_mux;
  logic                         opcode_valid;

  // Compressed encodings never get past the selector
  assign opcode_valid = instr_rdata[1:0] == 2'b11;

  base_decoder     base_dec (.instr_rdata(instr_rdata), .ctrl(base_ctrl));
  mul_div_decoder  md_dec   (.instr_rdata(instr_rdata), .ctrl(md_ctrl));
  bitmanip_decoder bm_dec   (.instr_rdata(instr_rdata), .ctrl(bm_ctrl));

  decode_select #(
    .M_EXT(M_EXT),
    .B_EXT(B_EXT)
  ) sel (
    .base_ctrl   (base_ctrl),
    .md_ctrl     (md_ctrl),
    .bm_ctrl     (bm_ctrl),
    .opcode_valid(opcode_valid),
    .ctrl_mux    (ctrl_mux)
  );

  // Word only loads on a strobe so it holds steady between instructions
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_valid <= 1'b0;
      // All-zero word, the illegal constant with its flag cleared
      ctrl       <= '0;
    end else begin
      ctrl_valid <= instr_valid;
      if (instr_valid) begin
        ctrl <= ctrl_mux;
      end
    end
  end

  // Atomics are not built, so an AMO strobe must come out illegal next cycle
  a_amo_illegal: assert property (@(posedge clk) disable iff (reset)
    instr_valid && instr_rdata[6:0] == rv_decode_pkg::OPCODE_AMO |=> ctrl.illegal_insn);

endmodule

`default_nettype wire

// ==== hdl/mul_div_decoder.sv ====
////////////////////////////////////////
// Multiply/divide extension decoder, combinational
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mul_div_decoder (
  input  wire [31:0]                   instr_rdata,
  output rv_decode_pkg::decoder_ctrl_t ctrl
);

  logic match;

  // The whole extension sits on OP with funct7 0000001
  assign match = instr_rdata[6:0] == rv_decode_pkg::OPCODE_OP && instr_rdata[31:25] == 7'h01;

  always_comb begin
    ctrl = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (match) begin
      ctrl.illegal_insn = 1'b0;
      // Funct3 bit 2 splits multiply from divide
      ctrl.mul_en       = !instr_rdata[14];
      ctrl.div_en       = instr_rdata[14];
      ctrl.md_op        = rv_decode_pkg::md_op_e'(instr_rdata[14:12]);
      // Multiplier reads rs1/rs2 itself, the divider goes through A and B
      if (instr_rdata[14]) begin
        ctrl.op_a_sel = rv_decode_pkg::OP_A_REG;
        ctrl.op_b_sel = rv_decode_pkg::OP_B_REG;
      end
      ctrl.rd_we = 1'b1;
      ctrl.rd    = instr_rdata[11:7];
      ctrl.rs1   = instr_rdata[19:15];
      ctrl.rs2   = instr_rdata[24:20];
    end
  end

  // Idle output must be the exact illegal word so the selector can skip it
  a_md_idle: assert property (@(instr_rdata)
    ctrl.illegal_insn |-> ctrl == rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN);

endmodule

`default_nettype wire

// ==== hdl/rv_decode_pkg.sv ====
////////////////////////////////////////
// Shared types for the decode stage, from opcodes to the
// control word that the execute stage receives
////////////////////////////////////////

`default_nettype none

package rv_decode_pkg;

  // Major opcodes of the 32-bit encoding, low two bits always 11
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_AMO      = 7'h2f,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  // Operand sources, NONE means the unit ignores that operand
  typedef enum logic [1:0] {OP_A_NONE, OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_NONE, OP_B_REG, OP_B_IMM} op_b_sel_e;

  // C carries store data or the second branch compare value, or the link address
  typedef enum logic [1:0] {OP_C_NONE, OP_C_REG, OP_C_PC4} op_c_sel_e;

  // ALU operations, add must stay at zero so the idle word selects it
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_ANDN, ALU_ORN, ALU_XNOR, ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU
  } alu_op_e;

  // Ordered as funct3 of the multiply/divide encodings
  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } md_op_e;

  // One decoded instruction as handed to execute
  typedef struct packed {
    logic        alu_en;
    logic        mul_en;
    logic        div_en;
    logic        csr_en;
    logic        sys_en;
    logic        lsu_en;
    logic        lsu_we;
    logic [1:0]  lsu_size;
    logic        lsu_signed;
    logic        illegal_insn;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    op_c_sel_e   op_c_sel;
    alu_op_e     alu_op;
    md_op_e      md_op;
    logic        rd_we;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } decoder_ctrl_t;

  // Idle word of every sub-decoder and the result for any unknown encoding
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en:       1'b0,
    mul_en:       1'b0,
    div_en:       1'b0,
    csr_en:       1'b0,
    sys_en:       1'b0,
    lsu_en:       1'b0,
    lsu_we:       1'b0,
    lsu_size:     2'b00,
    lsu_signed:   1'b0,
    illegal_insn: 1'b1,
    op_a_sel:     OP_A_NONE,
    op_b_sel:     OP_B_NONE,
    op_c_sel:     OP_C_NONE,
    alu_op:       ALU_ADD,
    md_op:        MD_MUL,
    rd_we:        1'b0,
    rd:           5'd0,
    rs1:          5'd0,
    rs2:          5'd0,
    imm:          32'd0
  };

endpackage

`default_nettype wire

// ==== src.f ====
hdl/rv_decode_pkg.sv
hdl/base_decoder.sv
hdl/mul_div_decoder.sv
hdl/bitmanip_decoder.sv
hdl/decode_select.sv
hdl/decode_stage.sv
tb/tb_clock.sv
tb/decode_stage_tb.sv

// ==== tb/decode_stage_tb.sv ====
////////////////////////////////////////
// Random-instruction testbench for the decode stage, with a decode
// reference model, an expected-word queue and a watchdog
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;

  localparam int N_INSTR     = 2000;
  localparam int CLK_NS      = 8;
  // Worst gap is two idle cycles so four cycles per instruction is a safe bound
  localparam int WATCHDOG_NS = N_INSTR * 4 * CLK_NS + 40 * CLK_NS;

  logic                         clk;
  logic                         reset;
  logic                         instr_valid;
  logic [31:0]                  instr_rdata;
  logic                         ctrl_valid;
  rv_decode_pkg::decoder_ctrl_t ctrl;

  rv_decode_pkg::decoder_ctrl_t expected_q[$];
  rv_decode_pkg::decoder_ctrl_t exp_word;
  rv_decode_pkg::decoder_ctrl_t last_word;
  logic [31:0]                  word;
  logic                         strobe_seen;
  int                           seed;
  int                           gap;

  tb_clock #(.PERIOD_NS(CLK_NS)) clk_gen (.clk(clk));

  decode_stage #(
    .M_EXT(1'b1),
    .B_EXT(1'b1)
  ) dut (
    .clk        (clk),
    .reset      (reset),
    .instr_valid(instr_valid),
    .instr_rdata(instr_rdata),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl)
  );

  ////////////////////////////////////////
  // Failure handling and compare tasks

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_ctrl(input rv_decode_pkg::decoder_ctrl_t got,
                            input rv_decode_pkg::decoder_ctrl_t exp, input string name);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: ctrl_valid got %b expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // Port-level view of the rule that exactly one unit or the illegal flag is set
  task automatic check_onehot(input rv_decode_pkg::decoder_ctrl_t got);
    logic [6:0] units;
    units = {got.alu_en, got.mul_en, got.div_en, got.csr_en, got.sys_en, got.lsu_en,
             got.illegal_insn};
    if (!$onehot(units)) begin
      $display("FAILED at %0t ns: ctrl unit enables got %b expected one-hot", $time, units);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Decode reference model

  // Branch compares follow funct3 and leave 010 and 011 unassigned
  function automatic rv_decode_pkg::alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return rv_decode_pkg::ALU_EQ;
      3'b001:  return rv_decode_pkg::ALU_NE;
      3'b100:  return rv_decode_pkg::ALU_LT;
      3'b101:  return rv_decode_pkg::ALU_GE;
      3'b110:  return rv_decode_pkg::ALU_LTU;
      default: return rv_decode_pkg::ALU_GEU;
    endcase
  endfunction

  // Shared by OP and OP-IMM with alt picking sub or sra where it applies
  function automatic rv_decode_pkg::alu_op_e int_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  return rv_decode_pkg::ALU_SLL;
      3'b010:  return rv_decode_pkg::ALU_SLT;
      3'b011:  return rv_decode_pkg::ALU_SLTU;
      3'b100:  return rv_decode_pkg::ALU_XOR;
      3'b101:  return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  return rv_decode_pkg::ALU_OR;
      default: return rv_decode_pkg::ALU_AND;
    endcase
  endfunction

  // Multiply/divide mnemonics by funct3 as listed in the M extension
  function automatic rv_decode_pkg::md_op_e md_op_of(input logic [2:0] f3);
    case (f3)
      3'b000:  return rv_decode_pkg::MD_MUL;
      3'b001:  return rv_decode_pkg::MD_MULH;
      3'b010:  return rv_decode_pkg::MD_MULHSU;
      3'b011:  return rv_decode_pkg::MD_MULHU;
      3'b100:  return rv_decode_pkg::MD_DIV;
      3'b101:  return rv_decode_pkg::MD_DIVU;
      3'b110:  return rv_decode_pkg::MD_REM;
      default: return rv_decode_pkg::MD_REMU;
    endcase
  endfunction

  task automatic expect_decode(input logic [31:0] w, output rv_decode_pkg::decoder_ctrl_t e);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic        ok;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    ok    = 1'b1;
    e     = '0;
    e.rd  = w[11:7];
    e.rs1 = w[19:15];
    e.rs2 = w[24:20];
    case (w[6:0])
      rv_decode_pkg::OPCODE_LUI, rv_decode_pkg::OPCODE_AUIPC: begin
        e.alu_en   = 1'b1;
        e.op_a_sel = w[5] ? rv_decode_pkg::OP_A_ZERO : rv_decode_pkg::OP_A_PC;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.rd_we    = 1'b1;
        e.imm      = {w[31:12], 12'h000};
      end
      rv_decode_pkg::OPCODE_JAL: begin
        e.alu_en   = 1'b1;
        e.op_a_sel = rv_decode_pkg::OP_A_PC;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.op_c_sel = rv_decode_pkg::OP_C_PC4;
        e.rd_we    = 1'b1;
        e.imm      = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      rv_decode_pkg::OPCODE_JALR: begin
        e.alu_en   = 1'b1;
        e.op_a_sel = rv_decode_pkg::OP_A_REG;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.op_c_sel = rv_decode_pkg::OP_C_PC4;
        e.rd_we    = 1'b1;
        e.imm      = imm_i;
        ok         = (f3 == 3'b000);
      end
      rv_decode_pkg::OPCODE_BRANCH: begin
        e.alu_en   = 1'b1;
        e.op_a_sel = rv_decode_pkg::OP_A_REG;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.op_c_sel = rv_decode_pkg::OP_C_REG;
        e.alu_op   = branch_op(f3);
        e.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        ok         = (f3[2:1] != 2'b01);
      end
      rv_decode_pkg::OPCODE_LOAD: begin
        e.lsu_en     = 1'b1;
        e.op_a_sel   = rv_decode_pkg::OP_A_REG;
        e.op_b_sel   = rv_decode_pkg::OP_B_IMM;
        e.lsu_size   = f3[1:0];
        e.lsu_signed = ~f3[2];
        e.rd_we      = 1'b1;
        e.imm        = imm_i;
        ok           = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
      end
      rv_decode_pkg::OPCODE_STORE: begin
        e.lsu_en   = 1'b1;
        e.lsu_we   = 1'b1;
        e.op_a_sel = rv_decode_pkg::OP_A_REG;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.op_c_sel = rv_decode_pkg::OP_C_REG;
        e.lsu_size = f3[1:0];
        e.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
        ok         = (f3 <= 3'b010);
      end
      rv_decode_pkg::OPCODE_OP_IMM: begin
        e.alu_en   = 1'b1;
        e.op_a_sel = rv_decode_pkg::OP_A_REG;
        e.op_b_sel = rv_decode_pkg::OP_B_IMM;
        e.rd_we    = 1'b1;
        e.imm      = imm_i;
        e.alu_op   = int_op(f3, f3 == 3'b101 && f7[5]);
        // Shift amounts fit in five bits and srai is the only upper pattern allowed
        if (f3 == 3'b001) ok = (f7 == 7'h00);
        if (f3 == 3'b101) ok = (f7 == 7'h00) || (f7 == 7'h20);
      end
      rv_decode_pkg::OPCODE_OP: begin
        e.rd_we = 1'b1;
        if (f7 == 7'h01) begin
          // Only the divide group routes its registers through A and B
          e.md_op = md_op_of(f3);
          if (e.md_op inside {rv_decode_pkg::MD_MUL, rv_decode_pkg::MD_MULH,
                              rv_decode_pkg::MD_MULHSU, rv_decode_pkg::MD_MULHU}) begin
            e.mul_en = 1'b1;
          end else begin
            e.div_en   = 1'b1;
            e.op_a_sel = rv_decode_pkg::OP_A_REG;
            e.op_b_sel = rv_decode_pkg::OP_B_REG;
          end
        end else begin
          e.alu_en   = 1'b1;
          e.op_a_sel = rv_decode_pkg::OP_A_REG;
          e.op_b_sel = rv_decode_pkg::OP_B_REG;
          if (f7 == 7'h00) begin
            e.alu_op = int_op(f3, 1'b0);
          end else if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) begin
            e.alu_op = int_op(f3, 1'b1);
          end else if (f7 == 7'h20 && f3 == 3'b111) begin
            e.alu_op = rv_decode_pkg::ALU_ANDN;
          end else if (f7 == 7'h20 && f3 == 3'b110) begin
            e.alu_op = rv_decode_pkg::ALU_ORN;
          end else if (f7 == 7'h20 && f3 == 3'b100) begin
            e.alu_op = rv_decode_pkg::ALU_XNOR;
          end else if (f7 == 7'h05 && f3[2]) begin
            // Min/max sit on funct3 100 to 111
            case (f3[1:0])
              2'b00:   e.alu_op = rv_decode_pkg::ALU_MIN;
              2'b01:   e.alu_op = rv_decode_pkg::ALU_MINU;
              2'b10:   e.alu_op = rv_decode_pkg::ALU_MAX;
              default: e.alu_op = rv_decode_pkg::ALU_MAXU;
            endcase
          end else begin
            ok = 1'b0;
          end
        end
      end
      rv_decode_pkg::OPCODE_MISC_MEM: begin
        e.sys_en = 1'b1;
        ok       = (f3 == 3'b000) || (f3 == 3'b001);
      end
      rv_decode_pkg::OPCODE_SYSTEM: begin
        if (f3 == 3'b000) begin
          // Ecall and ebreak plus the privileged mret and wfi
          e.sys_en = 1'b1;
          ok = (w[19:15] == 5'd0) && (w[11:7] == 5'd0) &&
               (w[31:20] == 12'h000 || w[31:20] == 12'h001 ||
                w[31:20] == 12'h302 || w[31:20] == 12'h105);
        end else begin
          e.csr_en   = 1'b1;
          e.op_a_sel = f3[2] ? rv_decode_pkg::OP_A_NONE : rv_decode_pkg::OP_A_REG;
          e.op_b_sel = rv_decode_pkg::OP_B_IMM;
          e.rd_we    = 1'b1;
          e.imm      = imm_i;
          ok         = (f3 != 3'b100);
        end
      end
      // AMO and every unknown opcode
      default: ok = 1'b0;
    endcase
    if (!ok || w[1:0] != 2'b11) e = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
  endtask

  ////////////////////////////////////////
  // Stimulus

  // Mostly legal opcodes with funct7 leaning toward assigned values
  task automatic make_word(output logic [31:0] w);
    logic [31:0] r;
    logic [6:0]  op;
    logic [11:0] sys_imm;
    int          pick;
    r = $random(seed);
    w = $random(seed);
    if (r[2:0] != 3'd0) begin
      pick = $unsigned($random(seed)) % 12;
      case (pick)
        0:       op = rv_decode_pkg::OPCODE_LOAD;
        1:       op = rv_decode_pkg::OPCODE_MISC_MEM;
        2:       op = rv_decode_pkg::OPCODE_OP_IMM;
        3:       op = rv_decode_pkg::OPCODE_AUIPC;
        4:       op = rv_decode_pkg::OPCODE_STORE;
        5:       op = rv_decode_pkg::OPCODE_AMO;
        6:       op = rv_decode_pkg::OPCODE_OP;
        7:       op = rv_decode_pkg::OPCODE_LUI;
        8:       op = rv_decode_pkg::OPCODE_BRANCH;
        9:       op = rv_decode_pkg::OPCODE_JALR;
        10:      op = rv_decode_pkg::OPCODE_JAL;
        default: op = rv_decode_pkg::OPCODE_SYSTEM;
      endcase
      w[6:0] = op;
      case (r[5:3])
        3'd0, 3'd1, 3'd2: w[31:25] = 7'h00;
        3'd3:             w[31:25] = 7'h20;
        3'd4:             w[31:25] = 7'h01;
        3'd5:             w[31:25] = 7'h05;
        default:          w[31:25] = w[31:25];
      endcase
      // Half of the system words get a privileged encoding that can pass
      if (op == rv_decode_pkg::OPCODE_SYSTEM && r[6]) begin
        case (r[8:7])
          2'd0:    sys_imm = 12'h000;
          2'd1:    sys_imm = 12'h001;
          2'd2:    sys_imm = 12'h302;
          default: sys_imm = 12'h105;
        endcase
        w[31:7] = {sys_imm, 13'd0};
      end
    end
  endtask

  initial begin
    seed        = 32'hbfda_6696;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr_rdata = 32'd0;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < N_INSTR; i++) begin
      @(posedge clk);
      #1;
      make_word(word);
      instr_valid = 1'b1;
      instr_rdata = word;
      expect_decode(word, exp_word);
      expected_q.push_back(exp_word);
      gap = $unsigned($random(seed)) % 3;
      // Idle cycles carry junk data that must not reach ctrl
      repeat (gap) begin
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr_rdata = $random(seed);
      end
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;
    while (expected_q.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);
    $display("All checks passed");
    $finish;
  end

  ////////////////////////////////////////
  // Output monitor sampling on the falling edge

  initial begin
    last_word = '0;
    @(posedge clk);
    forever begin
      // Inputs only move 1 ns after the edge so this is the value the DUT took
      strobe_seen = instr_valid && !reset;
      @(negedge clk);
      check_valid(ctrl_valid, strobe_seen);
      if (ctrl_valid) begin
        if (expected_q.size() == 0) begin
          $display("Error at %0t ns: ctrl_valid rose with no instruction outstanding", $time);
          abort_run();
        end
        exp_word = expected_q.pop_front();
        check_ctrl(ctrl, exp_word, "ctrl");
        check_onehot(ctrl);
        last_word = exp_word;
      end else begin
        check_ctrl(ctrl, last_word, "ctrl (held)");
      end
      @(posedge clk);
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
////////////////////////////////////////
// Free-running testbench clock, 8 ns period by default
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  // Starts low so the first rising edge lands at half a period
  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire
